//--- rtl/ahbPkg.sv
package ahbPkg;

  //////////////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////////////

  // One address space and one data word per beat
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  // One strobe bit per byte lane of the data word
  localparam int StrbWidth = DataWidth / 8;

  //////////////////////////////////////////////////////////////////////////////
  // Bus encodings
  //////////////////////////////////////////////////////////////////////////////

  // Transfer type as driven by the manager on HTRANS
  // The upper bit alone marks an active transfer (NONSEQ or SEQ)
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  // AHB-Lite only has the two-valued response
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hrespT;

  // Payload types
  typedef logic [AddrWidth-1:0] addrT;
  typedef logic [DataWidth-1:0] dataT;
  typedef logic [StrbWidth-1:0] strbT;

endpackage

//--- rtl/memMapPkg.sv
package memMapPkg;

  //////////////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////////////

  // The RAM window starts at the bottom of the map
  localparam ahbPkg::addrT RamBase = 32'h0000_0000;

  // Size of the RAM window in bytes, everything above it is unmapped
  localparam ahbPkg::addrT RamBytes = 32'd4096;

  // Geometry of the RAM array, one data word per row
  localparam int RamWords    = int'(RamBytes) / ahbPkg::StrbWidth;
  localparam int RamAddrBits = $clog2(RamWords);

  // Number of address bits that select a byte inside a word
  localparam int ByteOffset = $clog2(ahbPkg::StrbWidth);

  // Extra wait states on every RAM transfer
  // Zero gives the plain zero-wait RAM, values up to 15 stretch each beat
  localparam int RamLatency = 0;

  // Which slave owns an address phase or a data phase
  typedef enum logic {
    SlaveRam     = 1'b0,
    SlaveDefault = 1'b1
  } slaveIdxT;

endpackage

//--- rtl/ahbSlaveIf.sv
`timescale 1ns/1ps

interface ahbSlaveIf;

  // Address phase and write data, driven by the fabric
  logic          HSEL;
  ahbPkg::addrT   HADDR;
  ahbPkg::htransT HTRANS;
  logic          HWRITE;
  ahbPkg::dataT   HWDATA;
  ahbPkg::strbT   HWSTRB;

  // Global ready as seen by every slave, fed back from the response mux
  logic          HREADY;

  // Data phase response, driven by the slave
  ahbPkg::dataT   HRDATA;
  logic          HREADYOUT;
  ahbPkg::hrespT  HRESP;

  // The slave sees the request side and answers on the response side
  modport slave (
    input  HSEL, HADDR, HTRANS, HWRITE, HWDATA, HWSTRB, HREADY,
    output HRDATA, HREADYOUT, HRESP
  );

  // The fabric is the mirror image of a slave
  modport fabric (
    output HSEL, HADDR, HTRANS, HWRITE, HWDATA, HWSTRB, HREADY,
    input  HRDATA, HREADYOUT, HRESP
  );

endinterface

//--- rtl/ram1p1rwbe.sv
`timescale 1ns/1ps

module ram1p1rwbe (
  input  logic                              HCLK,
  input  logic [memMapPkg::RamAddrBits-1:0] addr,
  input  logic                              we,
  input  ahbPkg::strbT                      bwe,
  input  ahbPkg::dataT                      din,
  output ahbPkg::dataT                      dout
);

  // One data word per row, no reset on the storage
  ahbPkg::dataT mem [memMapPkg::RamWords];

  //////////////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////////////

  // Only the lanes with their strobe set are updated
  // Untouched lanes keep their old contents, which is what partial stores need
  always_ff @(posedge HCLK) begin
    if (we) begin
      for (int i = 0; i < ahbPkg::StrbWidth; i++) begin
        if (bwe[i]) begin
          mem[addr][i*8 +: 8] <= din[i*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////////////

  // The read word is registered every cycle on the same address
  // A write in the same cycle returns the old word, the new one appears next
  always_ff @(posedge HCLK) begin
    dout <= mem[addr];
  end

endmodule

//--- rtl/ramAhb.sv
`timescale 1ns/1ps

module ramAhb (
  input  logic       HCLK,
  input  logic       HRESETn,
  ahbSlaveIf.slave   bus
);

  // Start of a transfer in this cycle's address phase
  logic initTrans;
  logic memWrite;
  logic memRead;

  // Write flag and address carried into the data phase
  logic          memWriteD;
  ahbPkg::addrT  haddrD;

  // Address actually presented to the array
  ahbPkg::addrT  ramAddr;

  // Next value of the registered ready and the latency hold-off
  logic nextReady;
  logic delayReady;
  logic readyOut;

  // A transfer starts when we are selected, HTRANS is NONSEQ or SEQ and the
  // previous data phase on the bus is completing
  assign initTrans = bus.HREADY & bus.HSEL & bus.HTRANS[1];
  assign memWrite  = initTrans & bus.HWRITE;
  assign memRead   = initTrans & ~bus.HWRITE;

  //////////////////////////////////////////////////////////////////////////////
  // Address phase capture
  //////////////////////////////////////////////////////////////////////////////

  // Only advance when the bus does, so a stall holds the pending write
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      memWriteD <= 1'b0;
    end else if (bus.HREADY) begin
      memWriteD <= memWrite;
    end
  end

  always_ff @(posedge HCLK) begin
    if (bus.HREADY) begin
      haddrD <= bus.HADDR;
    end
  end

  // Write data shows up one cycle after its address, so the delayed address
  // lines up with HWDATA; in a wait state the delayed copy holds the stalled
  // address, otherwise the live address lets reads finish with zero wait
  assign ramAddr = (memWriteD | ~bus.HREADY) ? haddrD : bus.HADDR;

  //////////////////////////////////////////////////////////////////////////////
  // Ready and response
  //////////////////////////////////////////////////////////////////////////////

  // The array has one port, so a read arriving while a write is in its data
  // phase has to wait one cycle for the port to come free
  assign nextReady = ~(memWriteD & memRead) & ~delayReady;

  // Comes out of reset ready so the bus can start right away
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      readyOut <= 1'b1;
    end else begin
      readyOut <= nextReady;
    end
  end

  assign bus.HREADYOUT = readyOut;

  // Every RAM access inside the window succeeds
  assign bus.HRESP = ahbPkg::OKAY;

  // Array with the word index taken from the byte address
  ram1p1rwbe memory (
    .HCLK (HCLK),
    .addr (ramAddr[memMapPkg::RamAddrBits+memMapPkg::ByteOffset-1:memMapPkg::ByteOffset]),
    .we   (memWriteD),
    .bwe  (bus.HWSTRB),
    .din  (bus.HWDATA),
    .dout (bus.HRDATA)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Optional latency
  //////////////////////////////////////////////////////////////////////////////

  // Extra wait states stretch each beat, useful for exercising the manager
  if (memMapPkg::RamLatency > 0) begin : genLatency
    typedef enum logic {READY, DELAY} latStateT;

    latStateT currState;
    latStateT nextState;
    logic [$clog2(memMapPkg::RamLatency+1)-1:0] cycle;
    logic cycleFlag;

    // Counted enough wait cycles for this beat
    assign cycleFlag = int'(cycle) == memMapPkg::RamLatency;

    always_ff @(posedge HCLK) begin
      if (!HRESETn) begin
        currState <= READY;
      end else begin
        currState <= nextState;
      end
    end

    always_comb begin
      case (currState)
        READY:   nextState = (initTrans & ~cycleFlag) ? DELAY : READY;
        DELAY:   nextState = cycleFlag ? READY : DELAY;
        default: nextState = READY;
      endcase
    end

    // Counter runs while delaying and clears as soon as we return to ready
    always_ff @(posedge HCLK) begin
      if (!HRESETn || nextState == READY) begin
        cycle <= '0;
      end else begin
        cycle <= cycle + 1'b1;
      end
    end

    assign delayReady = nextState == DELAY;
  end else begin : genNoLatency
    assign delayReady = 1'b0;
  end

endmodule

//--- rtl/ahbDecoder.sv
`timescale 1ns/1ps

module ahbDecoder (
  input  ahbPkg::addrT         HADDR,
  ahbSlaveIf.fabric            ramBus,
  ahbSlaveIf.fabric            defBus,
  output memMapPkg::slaveIdxT  slaveSel
);

  // Offset of the address into the RAM window
  ahbPkg::addrT ramOffset;

  // Address falls inside the RAM window
  logic ramHit;

  //////////////////////////////////////////////////////////////////////////////
  // Window compare
  //////////////////////////////////////////////////////////////////////////////

  // Subtracting the base first turns the two-sided range check into one
  // unsigned compare, and addresses below the base wrap to large offsets
  assign ramOffset = HADDR - memMapPkg::RamBase;
  assign ramHit    = ramOffset < memMapPkg::RamBytes;

  //////////////////////////////////////////////////////////////////////////////
  // Selects
  //////////////////////////////////////////////////////////////////////////////

  // Exactly one select is high for every address
  // Anything outside the RAM window goes to the default slave
  assign ramBus.HSEL = ramHit;
  assign defBus.HSEL = ~ramHit;

  // The response mux latches this index to know who owns the data phase
  always_comb begin
    if (ramHit) begin
      slaveSel = memMapPkg::SlaveRam;
    end else begin
      slaveSel = memMapPkg::SlaveDefault;
    end
  end

  // The decode is purely on the address, HTRANS and HREADY are the
  // slaves' business when they decide whether a transfer starts

endmodule

//--- rtl/ahbDefaultSlave.sv
`timescale 1ns/1ps

module ahbDefaultSlave (
  input  logic       HCLK,
  input  logic       HRESETn,
  ahbSlaveIf.slave   bus
);

  // Idle, or first and second cycle of the error response
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    ERR1 = 2'b01,
    ERR2 = 2'b10
  } errStateT;

  errStateT state;
  errStateT nextState;

  // Active transfer accepted in this cycle's address phase
  logic initTrans;

  // IDLE and BUSY never count as a transfer, so they never start an error
  assign initTrans = bus.HREADY & bus.HSEL & bus.HTRANS[1];

  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  // A new unmapped transfer may be accepted in the second error cycle,
  // because HREADY is high there and the bus moves on
  always_comb begin
    case (state)
      IDLE:    nextState = initTrans ? ERR1 : IDLE;
      ERR1:    nextState = ERR2;
      ERR2:    nextState = initTrans ? ERR1 : IDLE;
      default: nextState = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////////////

  // The first error cycle holds the bus, the second releases it
  assign bus.HREADYOUT = state != ERR1;
  assign bus.HRESP     = (state == IDLE) ? ahbPkg::OKAY : ahbPkg::ERROR;

  // Nothing to read here
  assign bus.HRDATA    = '0;

endmodule

//--- rtl/ahbResponseMux.sv
`timescale 1ns/1ps

module ahbResponseMux (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  memMapPkg::slaveIdxT slaveSel,
  ahbSlaveIf.fabric           ramBus,
  ahbSlaveIf.fabric           defBus,
  output ahbPkg::dataT        HRDATA,
  output logic                HREADY,
  output ahbPkg::hrespT       HRESP
);

  // Slave whose data phase is currently on the bus
  memMapPkg::slaveIdxT owner;

  //////////////////////////////////////////////////////////////////////////////
  // Data phase owner
  //////////////////////////////////////////////////////////////////////////////

  // The address phase becomes the data phase only when HREADY is high
  // Out of reset the default slave owns the bus and it reports ready and OKAY
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      owner <= memMapPkg::SlaveDefault;
    end else if (HREADY) begin
      owner <= slaveSel;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Response select
  //////////////////////////////////////////////////////////////////////////////

  // Pure mux from the owner, HREADY also goes back to every slave
  always_comb begin
    if (owner == memMapPkg::SlaveRam) begin
      HRDATA = ramBus.HRDATA;
      HREADY = ramBus.HREADYOUT;
      HRESP  = ramBus.HRESP;
    end else begin
      HRDATA = defBus.HRDATA;
      HREADY = defBus.HREADYOUT;
      HRESP  = defBus.HRESP;
    end
  end

endmodule

//--- rtl/ahbRamSubsystem.sv
`timescale 1ns/1ps

module ahbRamSubsystem (
  input  logic           HCLK,
  input  logic           HRESETn,
  input  ahbPkg::addrT   HADDR,
  input  ahbPkg::htransT HTRANS,
  input  logic           HWRITE,
  input  ahbPkg::dataT   HWDATA,
  input  ahbPkg::strbT   HWSTRB,
  output ahbPkg::dataT   HRDATA,
  output logic           HREADY,
  output ahbPkg::hrespT  HRESP
);

  // Address phase owner as decoded this cycle
  memMapPkg::slaveIdxT slaveSel;

  // One bus bundle per slave
  ahbSlaveIf ramBus ();
  ahbSlaveIf defBus ();

  //////////////////////////////////////////////////////////////////////////////
  // Shared request signals
  //////////////////////////////////////////////////////////////////////////////

  // Both slaves see the same address phase and write data, only HSEL differs
  assign ramBus.HADDR  = HADDR;
  assign ramBus.HTRANS = HTRANS;
  assign ramBus.HWRITE = HWRITE;
  assign ramBus.HWDATA = HWDATA;
  assign ramBus.HWSTRB = HWSTRB;

  assign defBus.HADDR  = HADDR;
  assign defBus.HTRANS = HTRANS;
  assign defBus.HWRITE = HWRITE;
  assign defBus.HWDATA = HWDATA;
  assign defBus.HWSTRB = HWSTRB;

  // Global ready goes back to every slave so they all stall together
  assign ramBus.HREADY = HREADY;
  assign defBus.HREADY = HREADY;

  //////////////////////////////////////////////////////////////////////////////
  // Decode, slaves and response
  //////////////////////////////////////////////////////////////////////////////

  ahbDecoder u_ahbDecoder (
    .HADDR    (HADDR),
    .ramBus   (ramBus.fabric),
    .defBus   (defBus.fabric),
    .slaveSel (slaveSel)
  );

  ahbDefaultSlave u_ahbDefaultSlave (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .bus     (defBus.slave)
  );

  ramAhb u_ramAhb (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .bus     (ramBus.slave)
  );

  ahbResponseMux u_ahbResponseMux (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .slaveSel (slaveSel),
    .ramBus   (ramBus.fabric),
    .defBus   (defBus.fabric),
    .HRDATA   (HRDATA),
    .HREADY   (HREADY),
    .HRESP    (HRESP)
  );

endmodule

//--- verif/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic HCLK,
  output logic HRESETn
);

  // Free running clock with an 8 ns period
  initial begin
    HCLK = 1'b0;
    forever #4 HCLK = ~HCLK;
  end

  // Reset is held low over two rising edges, then released just after an edge
  initial begin
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
  end

endmodule

//--- verif/tbAhbRamSubsystem.sv
`timescale 1ns/1ps

module tbAhbRamSubsystem;

  // Transfers per test in the order full words, strobes, write-read, errors, idle/busy, random
  localparam int PlannedTransfers  = 16 + 12 + 6 + 3 + 4 + 200;
  localparam int CyclesPerTransfer = 3 + memMapPkg::RamLatency;
  localparam int TimeoutCycles     = 2 * PlannedTransfers * CyclesPerTransfer;
  localparam int RandomOps         = 200;

  // Random traffic stays in a block of 32 rows so that reads often find written data
  localparam int RandomRowBits     = 5;

  // Feedback taps of the Galois LFSR for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic           HCLK;
  logic           HRESETn;
  ahbPkg::addrT   HADDR;
  ahbPkg::htransT HTRANS;
  logic           HWRITE;
  ahbPkg::dataT   HWDATA;
  ahbPkg::strbT   HWSTRB;
  ahbPkg::dataT   HRDATA;
  logic           HREADY;
  ahbPkg::hrespT  HRESP;

  // Reference memory with one word per RAM row and a flag for rows written so far
  ahbPkg::dataT model [memMapPkg::RamWords];
  logic         known [memMapPkg::RamWords];

  logic [31:0] lfsrState;
  int          cycleCount = 0;
  int          errorCount = 0;

  clockGen clocks (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  ahbRamSubsystem i_ahbRamSubsystem (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HADDR   (HADDR),
    .HTRANS  (HTRANS),
    .HWRITE  (HWRITE),
    .HWDATA  (HWDATA),
    .HWSTRB  (HWSTRB),
    .HRDATA  (HRDATA),
    .HREADY  (HREADY),
    .HRESP   (HRESP)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic reportFailure();
    errorCount++;
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkData(input ahbPkg::dataT got, input ahbPkg::dataT exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      reportFailure();
    end
  endtask

  task automatic checkResp(input ahbPkg::hrespT got, input ahbPkg::hrespT exp,
                           input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %s expected %s", $time, what, got.name(), exp.name());
      reportFailure();
    end
  endtask

  task automatic checkReady(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, HREADY %b expected %b", $time, what, got, exp);
      reportFailure();
    end
  endtask

  task automatic checkWaits(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("mismatch at %0t: %s, %0d wait cycles expected %0d", $time, what, got, exp);
      reportFailure();
    end
  endtask

  // Counts clock edges and stops a run whose bus never completes a data phase
  always @(posedge HCLK) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout: the bus did not finish the tests within %0d cycles", cycleCount);
      reportFailure();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model and random source
  ////////////////////////////////////////////////////////////////////////////

  // Byte lanes with their strobe set take the new data, the others keep the old
  function automatic ahbPkg::dataT mergeBytes(input ahbPkg::dataT oldWord,
                                              input ahbPkg::dataT newWord,
                                              input ahbPkg::strbT strb);
    ahbPkg::dataT result;
    result = oldWord;
    for (int i = 0; i < ahbPkg::StrbWidth; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = newWord[i*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [memMapPkg::RamAddrBits-1:0] wordIndex(input ahbPkg::addrT addr);
    return addr[memMapPkg::RamAddrBits+memMapPkg::ByteOffset-1:memMapPkg::ByteOffset];
  endfunction

  // One LFSR step per bit and the bit shifted out goes into the result
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < count; i++) begin
      outBit    = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) begin
        lfsrState = lfsrState ^ LfsrTaps;
      end
      value = {value[30:0], outBit};
    end
    return value;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus manager
  ////////////////////////////////////////////////////////////////////////////

  // Outputs only depend on DUT registers, so what is seen 1 ns after an edge
  // is exactly what the next edge samples
  task automatic stepCycle(output logic ready, output ahbPkg::dataT data,
                           output ahbPkg::hrespT resp);
    ready = HREADY;
    data  = HRDATA;
    resp  = HRESP;
    @(posedge HCLK);
    #1;
  endtask

  // Hold the address phase until an edge with HREADY high takes it
  task automatic waitAccept();
    logic          ready;
    ahbPkg::dataT  data;
    ahbPkg::hrespT resp;
    ready = 1'b0;
    while (!ready) begin
      stepCycle(ready, data, resp);
    end
  endtask

  // Run the data phase to its end and count the low HREADY cycles
  task automatic waitDone(output ahbPkg::dataT data, output ahbPkg::hrespT resp,
                          output int waits);
    logic ready;
    waits = 0;
    stepCycle(ready, data, resp);
    while (!ready) begin
      waits++;
      stepCycle(ready, data, resp);
    end
  endtask

  task automatic idleBus();
    HTRANS = ahbPkg::IDLE;
    HWRITE = 1'b0;
  endtask

  task automatic ahbWrite(input ahbPkg::addrT addr, input ahbPkg::dataT data,
                          input ahbPkg::strbT strb, output ahbPkg::hrespT resp,
                          output int waits);
    ahbPkg::dataT unused;
    HADDR  = addr;
    HTRANS = ahbPkg::NONSEQ;
    HWRITE = 1'b1;
    waitAccept();
    idleBus();
    // Data and strobes belong to the data phase
    HWDATA = data;
    HWSTRB = strb;
    waitDone(unused, resp, waits);
  endtask

  task automatic ahbRead(input ahbPkg::addrT addr, output ahbPkg::dataT data,
                         output ahbPkg::hrespT resp, output int waits);
    HADDR  = addr;
    HTRANS = ahbPkg::NONSEQ;
    HWRITE = 1'b0;
    waitAccept();
    idleBus();
    waitDone(data, resp, waits);
  endtask

  task automatic ramWrite(input ahbPkg::addrT addr, input ahbPkg::dataT data,
                          input ahbPkg::strbT strb, input string what);
    ahbPkg::hrespT resp;
    int            waits;
    ahbWrite(addr, data, strb, resp, waits);
    checkResp(resp, ahbPkg::OKAY, what);
    checkWaits(waits, memMapPkg::RamLatency, what);
    model[wordIndex(addr)] = mergeBytes(model[wordIndex(addr)], data, strb);
    known[wordIndex(addr)] = 1'b1;
  endtask

  task automatic ramReadCheck(input ahbPkg::addrT addr, input string what);
    ahbPkg::dataT  data;
    ahbPkg::hrespT resp;
    int            waits;
    ahbRead(addr, data, resp, waits);
    checkResp(resp, ahbPkg::OKAY, what);
    checkWaits(waits, memMapPkg::RamLatency, what);
    checkData(data, model[wordIndex(addr)], what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic fullWordTest();
    ahbPkg::addrT addr;
    for (int i = 0; i < 8; i++) begin
      addr = ahbPkg::addrT'(i * 148);
      ramWrite(addr, ahbPkg::dataT'(32'h1357_9bdf ^ (i * 32'h0101_0101)), '1,
               $sformatf("full word write %0d", i));
    end
    for (int i = 0; i < 8; i++) begin
      addr = ahbPkg::addrT'(i * 148);
      ramReadCheck(addr, $sformatf("full word read %0d", i));
    end
  endtask

  task automatic strobeTest();
    ahbPkg::strbT strbList [4];
    ahbPkg::addrT addr;
    strbList = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    for (int i = 0; i < 4; i++) begin
      addr = ahbPkg::addrT'(32'h100 + i * 4);
      ramWrite(addr, 32'h1122_3344, '1, $sformatf("strobe base write %0d", i));
      ramWrite(addr, 32'hdead_beef, strbList[i], $sformatf("partial write %0d", i));
      ramReadCheck(addr, $sformatf("partial read %0d", i));
    end
  endtask

  // The read address phase sits in the write's data phase on the same word
  task automatic writeThenRead(input ahbPkg::addrT addr, input ahbPkg::dataT data,
                               input string what);
    ahbPkg::dataT  got;
    ahbPkg::hrespT resp;
    int            waits;
    HADDR  = addr;
    HTRANS = ahbPkg::NONSEQ;
    HWRITE = 1'b1;
    waitAccept();
    HWDATA = data;
    HWSTRB = '1;
    HWRITE = 1'b0;
    waitAccept();
    model[wordIndex(addr)] = data;
    known[wordIndex(addr)] = 1'b1;
    idleBus();
    waitDone(got, resp, waits);
    checkResp(resp, ahbPkg::OKAY, what);
    checkData(got, data, what);
    if (memMapPkg::RamLatency == 0) begin
      checkWaits(waits, 1, what);
    end
  endtask

  task automatic writeReadTest();
    writeThenRead(32'h200, 32'hcafe_0001, "write then read 0");
    writeThenRead(32'h204, 32'h5a5a_a5a5, "write then read 1");
    writeThenRead(32'hffc, 32'h0f1e_2d3c, "write then read last word");
  endtask

  // Unmapped space answers with one low and one high HREADY cycle and ERROR on both
  task automatic errorAccess(input ahbPkg::addrT addr, input ahbPkg::htransT kind,
                             input string what);
    logic          ready;
    ahbPkg::dataT  data;
    ahbPkg::hrespT resp;
    HADDR  = addr;
    HTRANS = kind;
    HWRITE = 1'b0;
    waitAccept();
    idleBus();
    stepCycle(ready, data, resp);
    checkReady(ready, 1'b0, {what, " first cycle"});
    checkResp(resp, ahbPkg::ERROR, {what, " first cycle"});
    stepCycle(ready, data, resp);
    checkReady(ready, 1'b1, {what, " second cycle"});
    checkResp(resp, ahbPkg::ERROR, {what, " second cycle"});
  endtask

  task automatic errorTest();
    errorAccess(32'h0000_1000, ahbPkg::NONSEQ, "unmapped NONSEQ");
    errorAccess(32'h8000_0010, ahbPkg::SEQ, "unmapped SEQ");
    ramReadCheck(32'h0, "RAM read after error");
  endtask

  // IDLE and BUSY carry a write flag but must not touch the array
  task automatic idleBusyTest();
    logic          ready;
    ahbPkg::dataT  data;
    ahbPkg::hrespT resp;
    ramWrite(32'h300, 32'h0bad_f00d, '1, "idle test setup");
    HADDR  = 32'h300;
    HTRANS = ahbPkg::IDLE;
    HWRITE = 1'b1;
    HWDATA = 32'hffff_ffff;
    HWSTRB = '1;
    stepCycle(ready, data, resp);
    checkReady(ready, 1'b1, "IDLE address phase");
    HTRANS = ahbPkg::BUSY;
    stepCycle(ready, data, resp);
    checkReady(ready, 1'b1, "IDLE data phase");
    checkResp(resp, ahbPkg::OKAY, "IDLE data phase");
    idleBus();
    stepCycle(ready, data, resp);
    checkReady(ready, 1'b1, "BUSY data phase");
    checkResp(resp, ahbPkg::OKAY, "BUSY data phase");
    ramReadCheck(32'h300, "RAM unchanged after IDLE and BUSY");
  endtask

  task automatic randomTest();
    logic [31:0]                      bits;
    logic                             isWrite;
    logic [memMapPkg::RamAddrBits-1:0] idx;
    ahbPkg::addrT                     addr;
    ahbPkg::dataT                     data;
    ahbPkg::strbT                     strb;
    for (int n = 0; n < RandomOps; n++) begin
      bits    = takeBits(1);
      isWrite = bits[0];
      bits    = takeBits(RandomRowBits);
      idx     = bits[memMapPkg::RamAddrBits-1:0];
      addr    = ahbPkg::addrT'(idx) << memMapPkg::ByteOffset;
      // A row that was never written has no defined contents, so fill it first
      if (!known[idx]) begin
        isWrite = 1'b1;
      end
      if (isWrite) begin
        data = takeBits(ahbPkg::DataWidth);
        bits = takeBits(ahbPkg::StrbWidth);
        strb = bits[ahbPkg::StrbWidth-1:0];
        if (!known[idx]) begin
          strb = '1;
        end
        ramWrite(addr, data, strb, $sformatf("random write %0d", n));
      end else begin
        ramReadCheck(addr, $sformatf("random read %0d", n));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    HADDR     = '0;
    HTRANS    = ahbPkg::IDLE;
    HWRITE    = 1'b0;
    HWDATA    = '0;
    HWSTRB    = '0;
    lfsrState = 32'hcb02;
    for (int i = 0; i < memMapPkg::RamWords; i++) begin
      known[i] = 1'b0;
      model[i] = '0;
    end

    // Reset release lands 1 ns after an edge where the inputs change too
    @(posedge HRESETn);
    checkReady(HREADY, 1'b1, "after reset");
    checkResp(HRESP, ahbPkg::OKAY, "after reset");

    fullWordTest();
    strobeTest();
    writeReadTest();
    errorTest();
    idleBusyTest();
    randomTest();

    if (errorCount == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      reportFailure();
    end
  end

endmodule

//--- project.f
rtl/ahbPkg.sv
rtl/memMapPkg.sv
rtl/ahbSlaveIf.sv
rtl/ram1p1rwbe.sv
rtl/ramAhb.sv
rtl/ahbDecoder.sv
rtl/ahbDefaultSlave.sv
rtl/ahbResponseMux.sv
rtl/ahbRamSubsystem.sv
verif/clockGen.sv
verif/tbAhbRamSubsystem.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing -f project.f --top-module tbAhbRamSubsystem -o simv \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
